/* holding_reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module holding_reg_bank
    import modbus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [REG_INDEX_BITS-1:0] reg_index,
    input  logic                      reg_wr_en,
    input  logic [15:0]               reg_wr_data,
    output logic [15:0]               reg_rd_data
);

    logic [15:0] regs [2**REG_INDEX_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_INDEX_BITS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr_en) begin
            regs[reg_index] <= reg_wr_data;
        end
    end

    // Read in the same cycle as the request
    assign reg_rd_data = regs[reg_index];

endmodule

`default_nettype wire

/* modbus_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module modbus_assertions (
    input logic       clk,
    input logic       rst,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       dispense_cmd,
    input logic       frame_error,
    input logic [7:0] func_code,
    input logic [3:0] dispense_item
);

    int fail_count = 0;

    dispense_single_pulse: assert property (
        @(posedge clk) disable iff (rst) dispense_cmd |=> !dispense_cmd)
        else begin
            $error("dispense_cmd high for two cycles in a row");
            fail_count++;
        end

    tx_single_pulse: assert property (
        @(posedge clk) disable iff (rst) tx_valid |=> !tx_valid)
        else begin
            $error("tx_valid high for two cycles in a row");
            fail_count++;
        end

    // A byte only goes out after the UART said ready
    tx_after_ready: assert property (
        @(posedge clk) disable iff (rst) tx_valid |-> $past(tx_ready))
        else begin
            $error("tx_valid without tx_ready in the previous cycle");
            fail_count++;
        end

    outputs_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> (!tx_valid && !frame_error && !dispense_cmd
                                       && func_code == 8'h00 && dispense_item == 4'h0))
        else begin
            $error("control outputs not cleared by reset");
            fail_count++;
        end

endmodule

bind modbus_slave_top modbus_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .dispense_cmd  (dispense_cmd),
    .frame_error   (frame_error),
    .func_code     (func_code),
    .dispense_item (dispense_item)
);

`default_nettype wire

/* modbus_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module modbus_checker
    import modbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic [63:0] req_bytes,
    input  logic [3:0]  req_len,
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    input  logic [7:0]  func_code,
    input  logic        frame_error,
    input  logic [3:0]  dispense_item,
    input  logic        dispense_cmd,
    output int          error_count,
    output int          check_count,
    output int          pending
);

    logic [15:0] regs_model [16];
    logic [7:0]  exp_q [$];
    logic [7:0]  exp_func;
    logic [3:0]  exp_item;
    logic [2:0]  err_pipe;
    logic [2:0]  disp_pipe;
    logic [2:0]  chk_pipe;
    int          short_pend;
    string       test_name;

    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    task automatic report(input string what, input logic [15:0] expected,
                          input logic [15:0] actual);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what,
                 expected, actual);
        error_count++;
    endtask

    // Expected bytes for one response with the CRC appended low byte first
    task automatic queue_response(input logic [47:0] body, input int blen);
        logic [15:0] crc;
        crc = CRC_INIT;
        for (int i = 0; i < blen; i++) begin
            exp_q.push_back(body[8*i +: 8]);
            crc = crc_step(crc, body[8*i +: 8]);
        end
        exp_q.push_back(crc[7:0]);
        exp_q.push_back(crc[15:8]);
    endtask

    always @(posedge clk) begin
        logic [7:0]  b [8];
        logic [15:0] crc;
        logic [15:0] value;
        logic        e_in;
        logic        d_in;
        logic        c_in;
        logic [7:0]  got;
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs_model[i] = 16'h0000;
            end
            exp_q.delete();
            exp_func  = 8'h00;
            exp_item  = 4'h0;
            err_pipe  = 3'b000;
            disp_pipe = 3'b000;
            chk_pipe  = 3'b000;
            short_pend = 0;
            error_count = 0;
            check_count = 0;
            test_name = "reset";
        end else begin
            e_in = 1'b0;
            d_in = 1'b0;
            c_in = 1'b0;
            // ==============================
            // Outputs two cycles after the last byte
            // ==============================
            check_count++;
            if (dispense_cmd !== disp_pipe[2]) begin
                report("dispense_cmd", {15'h0, disp_pipe[2]}, {15'h0, dispense_cmd});
            end else if (dispense_cmd && dispense_item !== exp_item) begin
                report("dispense_item", {12'h0, exp_item}, {12'h0, dispense_item});
            end
            if (err_pipe[2] && !frame_error) begin
                report("frame_error", 16'h1, 16'h0);
            end
            if (frame_error && !err_pipe[2]) begin
                if (short_pend > 0) begin
                    short_pend--;
                end else begin
                    report("frame_error", 16'h0, 16'h1);
                end
            end
            if (chk_pipe[2] && func_code !== exp_func) begin
                report("func_code", {8'h00, exp_func}, {8'h00, func_code});
            end
            if (tx_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected response byte %h after test %s", tx_data, test_name);
                    error_count++;
                end else begin
                    got = exp_q.pop_front();
                    check_count++;
                    if (tx_data !== got) begin
                        report("tx byte", {8'h00, got}, {8'h00, tx_data});
                    end
                end
            end
            // ==============================
            // Model of a new request
            // ==============================
            if (req_valid) begin
                for (int i = 0; i < 8; i++) begin
                    b[i] = req_bytes[8*i +: 8];
                end
                if (req_len != 4'd8) begin
                    test_name = "truncated";
                    short_pend = 1;
                end else begin
                    crc = CRC_INIT;
                    for (int i = 0; i < 6; i++) begin
                        crc = crc_step(crc, b[i]);
                    end
                    value = {b[4], b[5]};
                    c_in = 1'b1;
                    if (b[0] != SLAVE_ADDR) begin
                        test_name = "foreign";
                    end else if (crc != {b[7], b[6]}) begin
                        test_name = "bad_crc";
                        e_in = 1'b1;
                        queue_response({24'h0, EXC_DEVICE_FAILURE, b[1] | EXC_FLAG, SLAVE_ADDR}, 3);
                    end else begin
                        exp_func = b[1];
                        case (b[1])
                            FUNC_READ_HOLDING: begin
                                test_name = "read";
                                queue_response({8'h00, regs_model[b[3][3:0]][7:0],
                                                regs_model[b[3][3:0]][15:8], 8'h02,
                                                FUNC_READ_HOLDING, SLAVE_ADDR}, 5);
                            end
                            FUNC_WRITE_SINGLE: begin
                                test_name = "write";
                                regs_model[b[3][3:0]] = value;
                                if ({b[2], b[3]} == DISPENSE_ADDR) begin
                                    d_in = 1'b1;
                                    exp_item = value[3:0];
                                end
                                queue_response(req_bytes[47:0], 6);
                            end
                            default: begin
                                test_name = "unsupported";
                                queue_response({24'h0, EXC_ILLEGAL_FUNCTION, b[1] | EXC_FLAG,
                                                SLAVE_ADDR}, 3);
                            end
                        endcase
                    end
                end
            end
            err_pipe  = {err_pipe[1:0], e_in};
            disp_pipe = {disp_pipe[1:0], d_in};
            chk_pipe  = {chk_pipe[1:0], c_in};
        end
        pending = exp_q.size() + short_pend;
    end

endmodule

`default_nettype wire

/* modbus_crc16.sv */
`timescale 1ns/1ns
`default_nettype none

module modbus_crc16
    import modbus_pkg::*;
(
    input  logic [15:0] crc_in,
    input  logic [7:0]  data_byte,
    output logic [15:0] crc_out
);

    logic [15:0] crc_work;

    // LSB-first, one bit per step
    always_comb begin
        crc_work = crc_in ^ {8'h00, data_byte};
        for (int i = 0; i < 8; i++) begin
            if (crc_work[0]) begin
                crc_work = (crc_work >> 1) ^ CRC_POLY;
            end else begin
                crc_work = crc_work >> 1;
            end
        end
        crc_out = crc_work;
    end

endmodule

`default_nettype wire

/* modbus_pkg.sv */
`default_nettype none

package modbus_pkg;

    // ==============================
    // Protocol constants
    // ==============================
    localparam logic [7:0] SLAVE_ADDR = 8'h01;

    localparam logic [7:0] FUNC_READ_HOLDING = 8'h03;
    localparam logic [7:0] FUNC_WRITE_SINGLE = 8'h06;

    // OR'd into the function code of an exception reply
    localparam logic [7:0] EXC_FLAG             = 8'h80;
    localparam logic [7:0] EXC_ILLEGAL_FUNCTION = 8'h01;
    localparam logic [7:0] EXC_DEVICE_FAILURE   = 8'h04;

    localparam logic [15:0] DISPENSE_ADDR = 16'h0100;

    // Request length including the two CRC bytes
    localparam int FRAME_BYTES = 8;

    // ==============================
    // Line timing, in clock cycles
    // ==============================
    localparam logic [15:0] GAP_START_CYCLES = 16'd35;
    localparam logic [15:0] GAP_END_CYCLES   = 16'd15;

    // CRC-16 Modbus, reflected form
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;

    localparam int REG_INDEX_BITS = 4;

    // Request bytes 4 and 5, high byte first on the wire
    typedef union packed {
        logic [15:0] reg_count;
        logic [15:0] reg_value;
    } req_data_t;

endpackage

`default_nettype wire

/* modbus_request_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module modbus_request_engine
    import modbus_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     frame_done,
    input  logic                     short_frame,
    input  logic                     crc_ok,
    input  logic [7:0]               rx_slave,
    input  logic [7:0]               rx_func,
    input  logic [15:0]              rx_reg_addr,
    input  req_data_t                rx_data_word,
    input  logic [8*FRAME_BYTES-1:0] frame_bytes,
    output logic [47:0]              resp_body,
    output logic [2:0]               resp_len,
    output logic                     resp_start,
    output logic [7:0]               func_code,
    output logic                     frame_error,
    output logic [3:0]               dispense_item,
    output logic                     dispense_cmd
);

    logic [REG_INDEX_BITS-1:0] reg_index;
    logic                      reg_wr_en;
    logic [15:0]               reg_wr_data;
    logic [15:0]               reg_rd_data;
    logic                      addr_match;
    logic                      served;
    logic                      dispense_hit;
    logic [47:0]               body_next;
    logic [2:0]                len_next;

    assign addr_match = (rx_slave == SLAVE_ADDR);

    // Addressed to us with a good CRC
    assign served = frame_done && addr_match && crc_ok;

    assign reg_index    = rx_reg_addr[REG_INDEX_BITS-1:0];
    assign reg_wr_en    = served && (rx_func == FUNC_WRITE_SINGLE);
    assign reg_wr_data  = rx_data_word.reg_value;
    assign dispense_hit = reg_wr_en && (rx_reg_addr == DISPENSE_ADDR);

    holding_reg_bank u_bank (
        .clk         (clk),
        .rst         (rst),
        .reg_index   (reg_index),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_data (reg_wr_data),
        .reg_rd_data (reg_rd_data)
    );

    // ==============================
    // Response body, byte 0 lowest
    // ==============================
    always_comb begin
        body_next = '0;
        len_next  = 3'd3;
        if (!crc_ok) begin
            body_next[23:0] = {EXC_DEVICE_FAILURE, rx_func | EXC_FLAG, SLAVE_ADDR};
        end else begin
            case (rx_func)
                FUNC_READ_HOLDING: begin
                    // One register, so the byte count is always 2
                    body_next[39:0] = {reg_rd_data[7:0], reg_rd_data[15:8], 8'h02,
                                       FUNC_READ_HOLDING, SLAVE_ADDR};
                    len_next        = 3'd5;
                end
                FUNC_WRITE_SINGLE: begin
                    // Echo of the request without its CRC
                    body_next = frame_bytes[8*(FRAME_BYTES-2)-1:0];
                    len_next  = 3'd6;
                end
                default: begin
                    body_next[23:0] = {EXC_ILLEGAL_FUNCTION, rx_func | EXC_FLAG, SLAVE_ADDR};
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_start    <= 1'b0;
            frame_error   <= 1'b0;
            dispense_cmd  <= 1'b0;
            dispense_item <= '0;
            func_code     <= '0;
        end else begin
            resp_start   <= frame_done && addr_match;
            frame_error  <= short_frame || (frame_done && addr_match && !crc_ok);
            dispense_cmd <= dispense_hit;
            if (dispense_hit) begin
                dispense_item <= rx_data_word.reg_value[3:0];
            end
            if (served) begin
                func_code <= rx_func;
            end
        end
    end

    // Foreign frames leave the last response untouched
    always_ff @(posedge clk) begin
        if (frame_done && addr_match) begin
            resp_body <= body_next;
            resp_len  <= len_next;
        end
    end

endmodule

`default_nettype wire

/* modbus_slave_top.sv */
`timescale 1ns/1ns
`default_nettype none

module modbus_slave_top
    import modbus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic [7:0] func_code,
    output logic       frame_error,
    output logic [3:0] dispense_item,
    output logic       dispense_cmd
);

    logic                     byte_seen;
    logic                     gap_end;
    logic                     gap_start;
    logic                     busy;
    logic                     frame_done;
    logic                     short_frame;
    logic                     crc_ok;
    logic [7:0]               rx_slave;
    logic [7:0]               rx_func;
    logic [15:0]              rx_reg_addr;
    req_data_t                rx_data_word;
    logic [8*FRAME_BYTES-1:0] frame_bytes;
    logic [47:0]              resp_body;
    logic [2:0]               resp_len;
    logic                     resp_start;

    rtu_silence_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .byte_seen (byte_seen),
        .gap_end   (gap_end),
        .gap_start (gap_start)
    );

    rtu_rx_framer u_framer (
        .clk          (clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .gap_end      (gap_end),
        .gap_start    (gap_start),
        .busy         (busy),
        .byte_seen    (byte_seen),
        .frame_done   (frame_done),
        .short_frame  (short_frame),
        .crc_ok       (crc_ok),
        .rx_slave     (rx_slave),
        .rx_func      (rx_func),
        .rx_reg_addr  (rx_reg_addr),
        .rx_data_word (rx_data_word),
        .frame_bytes  (frame_bytes)
    );

    modbus_request_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .frame_done    (frame_done),
        .short_frame   (short_frame),
        .crc_ok        (crc_ok),
        .rx_slave      (rx_slave),
        .rx_func       (rx_func),
        .rx_reg_addr   (rx_reg_addr),
        .rx_data_word  (rx_data_word),
        .frame_bytes   (frame_bytes),
        .resp_body     (resp_body),
        .resp_len      (resp_len),
        .resp_start    (resp_start),
        .func_code     (func_code),
        .frame_error   (frame_error),
        .dispense_item (dispense_item),
        .dispense_cmd  (dispense_cmd)
    );

    rtu_tx_sender u_sender (
        .clk        (clk),
        .rst        (rst),
        .resp_body  (resp_body),
        .resp_len   (resp_len),
        .resp_start (resp_start),
        .gap_start  (gap_start),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .busy       (busy)
    );

endmodule

`default_nettype wire

/* rtu_rx_framer.sv */
`timescale 1ns/1ns
`default_nettype none

module rtu_rx_framer
    import modbus_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               rx_data,
    input  logic                     rx_valid,
    input  logic                     gap_end,
    input  logic                     gap_start,
    input  logic                     busy,
    output logic                     byte_seen,
    output logic                     frame_done,
    output logic                     short_frame,
    output logic                     crc_ok,
    output logic [7:0]               rx_slave,
    output logic [7:0]               rx_func,
    output logic [15:0]              rx_reg_addr,
    output req_data_t                rx_data_word,
    output logic [8*FRAME_BYTES-1:0] frame_bytes
);

    logic [$clog2(FRAME_BYTES)-1:0] byte_idx;
    logic                           receiving;
    logic                           done_pend;
    logic                           accept;
    logic [15:0]                    crc_q;
    logic [15:0]                    crc_next;
    logic [8*FRAME_BYTES-1:0]       frame_q;

    // Any byte outside a response restarts the silence count
    assign byte_seen = rx_valid && !busy;

    // First byte needs the full start gap
    assign accept = byte_seen && (receiving || gap_start);

    modbus_crc16 u_crc (
        .crc_in    (crc_q),
        .data_byte (rx_data),
        .crc_out   (crc_next)
    );

    // ==============================
    // Frame control
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            receiving   <= 1'b0;
            byte_idx    <= '0;
            done_pend   <= 1'b0;
            crc_q       <= CRC_INIT;
            frame_done  <= 1'b0;
            short_frame <= 1'b0;
            crc_ok      <= 1'b0;
        end else begin
            done_pend   <= 1'b0;
            frame_done  <= 1'b0;
            short_frame <= 1'b0;
            if (accept) begin
                crc_q <= crc_next;
                if (byte_idx == ($clog2(FRAME_BYTES))'(FRAME_BYTES - 1)) begin
                    receiving <= 1'b0;
                    byte_idx  <= '0;
                    done_pend <= 1'b1;
                end else begin
                    receiving <= 1'b1;
                    byte_idx  <= byte_idx + 1'b1;
                end
            end else if (receiving && gap_end) begin
                // Line went quiet mid-frame
                receiving   <= 1'b0;
                byte_idx    <= '0;
                crc_q       <= CRC_INIT;
                short_frame <= 1'b1;
            end
            if (done_pend) begin
                // Residue over data plus CRC is zero for a good frame
                frame_done <= 1'b1;
                crc_ok     <= (crc_q == 16'h0000);
                crc_q      <= CRC_INIT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q[8*byte_idx +: 8] <= rx_data;
        end
    end

    assign frame_bytes  = frame_q;
    assign rx_slave     = frame_q[7:0];
    assign rx_func      = frame_q[15:8];
    assign rx_reg_addr  = {frame_q[23:16], frame_q[31:24]};
    assign rx_data_word = {frame_q[39:32], frame_q[47:40]};

endmodule

`default_nettype wire

/* rtu_silence_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module rtu_silence_timer
    import modbus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic byte_seen,
    output logic gap_end,
    output logic gap_start
);

    logic [15:0] idle_cnt;

    // Saturates once the start gap is reached
    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if (byte_seen) begin
            idle_cnt <= '0;
        end else if (idle_cnt < GAP_START_CYCLES) begin
            idle_cnt <= idle_cnt + 16'd1;
        end
    end

    assign gap_end   = (idle_cnt >= GAP_END_CYCLES);
    assign gap_start = (idle_cnt >= GAP_START_CYCLES);

endmodule

`default_nettype wire

/* rtu_tx_sender.sv */
`timescale 1ns/1ns
`default_nettype none

module rtu_tx_sender
    import modbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [47:0] resp_body,
    input  logic [2:0]  resp_len,
    input  logic        resp_start,
    input  logic        gap_start,
    input  logic        tx_ready,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    output logic        busy
);

    logic        sending;
    logic [3:0]  idx;
    logic [3:0]  total;
    logic        send_now;
    logic [47:0] body_q;
    logic [2:0]  len_q;
    logic [15:0] crc_q;
    logic [15:0] crc_next;
    logic [7:0]  body_byte;
    logic [7:0]  tx_byte;

    // Body plus two CRC bytes
    assign total     = {1'b0, len_q} + 4'd2;
    assign send_now  = sending && (idx != total) && tx_ready && !tx_valid;
    assign body_byte = body_q[8*idx[2:0] +: 8];

    modbus_crc16 u_crc (
        .crc_in    (crc_q),
        .data_byte (body_byte),
        .crc_out   (crc_next)
    );

    // CRC goes out low byte first
    always_comb begin
        if (idx < {1'b0, len_q}) begin
            tx_byte = body_byte;
        end else if (idx == {1'b0, len_q}) begin
            tx_byte = crc_q[7:0];
        end else begin
            tx_byte = crc_q[15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            sending  <= 1'b0;
            tx_valid <= 1'b0;
            idx      <= '0;
            crc_q    <= CRC_INIT;
        end else begin
            tx_valid <= 1'b0;
            if (!busy) begin
                if (resp_start) begin
                    busy  <= 1'b1;
                    idx   <= '0;
                    crc_q <= CRC_INIT;
                end
            end else if (!sending) begin
                sending <= gap_start;
            end else if (idx == total) begin
                busy    <= 1'b0;
                sending <= 1'b0;
            end else if (send_now) begin
                tx_valid <= 1'b1;
                idx      <= idx + 4'd1;
                if (idx < {1'b0, len_q}) begin
                    crc_q <= crc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && resp_start) begin
            body_q <= resp_body;
            len_q  <= resp_len;
        end
        if (send_now) begin
            tx_data <= tx_byte;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
verilator --binary --timing --assert --top-module tb_modbus_slave -f tb.f -o sim_modbus \
    && ./obj_dir/sim_modbus | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

/* tb.f */
modbus_pkg.sv
modbus_crc16.sv
rtu_silence_timer.sv
rtu_rx_framer.sv
holding_reg_bank.sv
modbus_request_engine.sv
rtu_tx_sender.sv
modbus_slave_top.sv
modbus_assertions.sv
modbus_checker.sv
tb_modbus_slave.sv

/* tb_modbus_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_modbus_slave
    import modbus_pkg::*;
();

    localparam logic [31:0] SEED           = 32'hcbba_cdca;
    localparam int          NUM_FRAMES     = 60;
    localparam int          TIMEOUT_CYCLES = NUM_FRAMES * 250;

    logic        clk;
    logic        rst;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        tx_ready = 1'b1;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic [7:0]  func_code;
    logic        frame_error;
    logic [3:0]  dispense_item;
    logic        dispense_cmd;
    logic        req_valid;
    logic [63:0] req_bytes;
    logic [3:0]  req_len;
    int          error_count;
    int          check_count;
    int          pending;
    int          cycles = 0;
    int          stall_left = 0;
    logic [31:0] stim_state = SEED;
    logic [31:0] bp_state = SEED;

    modbus_slave_top UUT (
        .clk           (clk),
        .rst           (rst),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .func_code     (func_code),
        .frame_error   (frame_error),
        .dispense_item (dispense_item),
        .dispense_cmd  (dispense_cmd)
    );

    modbus_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_bytes     (req_bytes),
        .req_len       (req_len),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .func_code     (func_code),
        .frame_error   (frame_error),
        .dispense_item (dispense_item),
        .dispense_cmd  (dispense_cmd),
        .error_count   (error_count),
        .check_count   (check_count),
        .pending       (pending)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            stim_state = lfsr_next(stim_state);
            v = {v[30:0], stim_state[0]};
        end
    endtask

    function automatic logic [15:0] frame_crc(input logic [47:0] body);
        logic [15:0] c;
        c = CRC_INIT;
        for (int i = 0; i < 6; i++) begin
            c = c ^ {8'h00, body[8*i +: 8]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
            end
        end
        return c;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // UART back-pressure after every accepted byte
    always @(negedge clk) begin
        if (tx_valid) begin
            bp_state = lfsr_next(bp_state);
            stall_left = int'(bp_state[0]);
            bp_state = lfsr_next(bp_state);
            stall_left = stall_left * 2 + int'(bp_state[0]);
            tx_ready = (stall_left == 0);
        end else if (stall_left != 0) begin
            stall_left--;
            tx_ready = (stall_left == 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a response or frame error never came", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ==============================
    // One random request frame
    // ==============================
    task automatic send_frame();
        logic [31:0] r;
        logic [2:0]  kind;
        logic [15:0] addr;
        logic [15:0] value;
        logic [7:0]  slave;
        logic [7:0]  func;
        logic [63:0] fb;
        int          n;
        int          bi;
        rand_bits(3, r);
        kind = r[2:0];
        rand_bits(5, r);
        addr = r[4] ? DISPENSE_ADDR : {12'h000, r[3:0]};
        rand_bits(16, r);
        value = r[15:0];
        rand_bits(1, r);
        func = r[0] ? FUNC_WRITE_SINGLE : FUNC_READ_HOLDING;
        if (kind < 3'd2 || kind == 3'd7) begin
            func = FUNC_WRITE_SINGLE;
        end else if (kind < 3'd4) begin
            func = FUNC_READ_HOLDING;
        end else if (kind == 3'd6) begin
            rand_bits(4, r);
            func = 8'h40 | {4'h0, r[3:0]};
        end
        slave = SLAVE_ADDR;
        if (kind == 3'd5) begin
            rand_bits(4, r);
            slave = 8'h10 | {4'h0, r[3:0]};
        end
        fb[47:0] = {value[7:0], value[15:8], addr[7:0], addr[15:8], func, slave};
        // CRC low byte lands in byte 6
        fb[63:48] = frame_crc(fb[47:0]);
        if (kind == 3'd4) begin
            // Flip one bit past the address byte
            rand_bits(6, r);
            bi = 8 + int'(r[5:0]) % 56;
            fb[bi] = ~fb[bi];
        end
        n = 8;
        if (kind == 3'd7) begin
            rand_bits(3, r);
            n = 1 + int'(r[2:0]) % 7;
        end
        repeat (int'(GAP_START_CYCLES) + 5) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            rx_data  = fb[8*i +: 8];
            rx_valid = 1'b1;
            if (i == n - 1) begin
                req_valid = 1'b1;
                req_bytes = fb;
                req_len   = 4'(n);
            end
            @(negedge clk);
            rx_valid  = 1'b0;
            req_valid = 1'b0;
            rand_bits(3, r);
            repeat (r[2:0]) @(negedge clk);
        end
    endtask

    initial begin
        rst       = 1'b1;
        rx_data   = 8'h00;
        rx_valid  = 1'b0;
        req_valid = 1'b0;
        req_bytes = 64'h0;
        req_len   = 4'h0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
            while (pending != 0) @(negedge clk);
        end
        repeat (10) @(negedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
                 error_count, UUT.u_assertions.fail_count);
        if (error_count == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
